//--- hw/mod_arith_defines.svh
`ifndef MOD_ARITH_DEFINES_SVH
`define MOD_ARITH_DEFINES_SVH

// ======================================================================
// Datapath width
// ======================================================================

// Operand, prime and result width in bits
// 64 keeps simulation fast, 384 matches the full-size accelerator
`define REG_SIZE 64

// ======================================================================
// Operand memory geometry
// ======================================================================

// Number of words in the shared operand memory
`define MEM_DEPTH 16

// Address width, must cover MEM_DEPTH
`define MEM_AW 4

`endif

//--- hw/mod_arith_pkg.sv
`include "mod_arith_defines.svh"

package mod_arith_pkg;

    // ==================================================================
    // Datapath types
    // ==================================================================

    // One operand word, also used for the prime and the results
    typedef logic [`REG_SIZE-1:0] word_t;

    // Operand memory address
    typedef logic [`MEM_AW-1:0] addr_t;

    // ==================================================================
    // Control encodings
    // ==================================================================

    // Requester index at the memory arbiter
    typedef enum logic [1:0] {
        REQ_HOST  = 2'd0,
        REQ_LANE0 = 2'd1,
        REQ_LANE1 = 2'd2
    } req_id_e;

    // Lane operation, one bit on the command port
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } lane_op_e;

endpackage

//--- hw/add_sub_mod.sv
`timescale 1ns/1ps
`include "mod_arith_defines.svh"

module add_sub_mod (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 add_en_i,
    input  logic                 sub_i,
    input  mod_arith_pkg::word_t opa_i,
    input  mod_arith_pkg::word_t opb_i,
    input  mod_arith_pkg::word_t prime_i,
    output mod_arith_pkg::word_t res_o,
    output logic                 ready_o
);
    import mod_arith_pkg::*;

    // Stage one, combinational
    word_t      opb0;
    word_t      r0;
    logic       carry0;

    // Stage one registers
    word_t      r0_reg;
    logic       carry0_reg;
    word_t      opb1;
    logic       sub_n;

    // Stage two, combinational
    word_t      r1;
    logic       carry1;

    // Ready pulse shifter
    logic [1:0] push_q;

    // ==================================================================
    // Stage one: opa + opb, or opa + ~opb + 1 for subtraction
    // ==================================================================

    assign opb0 = sub_i ? ~opb_i : opb_i;

    // Carry out lands in the extra top bit
    assign {carry0, r0} = {1'b0, opa_i} + {1'b0, opb0} + {{`REG_SIZE{1'b0}}, sub_i};

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            r0_reg     <= '0;
            carry0_reg <= 1'b0;
            opb1       <= '0;
            sub_n      <= 1'b0;
        end else if (add_en_i) begin
            r0_reg     <= r0;
            carry0_reg <= carry0;
            sub_n      <= ~sub_i;
            // Correction operand for stage two
            // add needs r0 - p, sub needs r0 + p
            opb1       <= sub_i ? prime_i : ~prime_i;
        end
    end

    // ==================================================================
    // Stage two: apply the correction by p
    // ==================================================================

    // sub_n doubles as the carry-in that completes the two's complement of p
    assign {carry1, r1} = {1'b0, r0_reg} + {1'b0, opb1} + {{`REG_SIZE{1'b0}}, sub_n};

    always_comb begin
        if (sub_n) begin
            // Addition: take r0 - p when the sum overflowed or reached p
            res_o = (carry0_reg ^ carry1) ? r1 : r0_reg;
        end else begin
            // Subtraction: no borrow means a >= b, keep the raw difference
            res_o = carry0_reg ? r0_reg : r1;
        end
    end

    // ==================================================================
    // Ready pulse, two edges after add_en_i
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            push_q <= 2'b00;
        end else if (zeroize_i) begin
            push_q <= 2'b00;
        end else if (add_en_i) begin
            push_q <= 2'b10;
        end else begin
            push_q <= {1'b0, push_q[1]};
        end
    end

    assign ready_o = push_q[0];

endmodule

//--- hw/operand_ram.sv
`timescale 1ns/1ps
`include "mod_arith_defines.svh"

module operand_ram (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize_i,
    input  logic                 en_i,
    input  logic                 we_i,
    input  mod_arith_pkg::addr_t addr_i,
    input  mod_arith_pkg::word_t wdata_i,
    output mod_arith_pkg::word_t rdata_o
);
    import mod_arith_pkg::*;

    // Word storage, contents survive reset
    word_t mem [`MEM_DEPTH];

    // Write port, zeroize wipes every word
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Registered read, data valid one cycle after the enabled read
    // Holds its value until the next read
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rdata_o <= '0;
        end else if (zeroize_i) begin
            rdata_o <= '0;
        end else if (en_i && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk,
    input  logic                 reset_n,
    // Host, never refused
    input  logic                 host_we_i,
    input  logic                 host_re_i,
    input  mod_arith_pkg::addr_t host_addr_i,
    input  mod_arith_pkg::word_t host_wdata_i,
    // Lane 0
    input  logic                 lane0_req_i,
    input  logic                 lane0_we_i,
    input  mod_arith_pkg::addr_t lane0_addr_i,
    input  mod_arith_pkg::word_t lane0_wdata_i,
    output logic                 lane0_gnt_o,
    // Lane 1
    input  logic                 lane1_req_i,
    input  logic                 lane1_we_i,
    input  mod_arith_pkg::addr_t lane1_addr_i,
    input  mod_arith_pkg::word_t lane1_wdata_i,
    output logic                 lane1_gnt_o,
    // Memory port
    input  mod_arith_pkg::word_t ram_rdata_i,
    output logic                 ram_en_o,
    output logic                 ram_we_o,
    output mod_arith_pkg::addr_t ram_addr_o,
    output mod_arith_pkg::word_t ram_wdata_o,
    output mod_arith_pkg::word_t rdata_o
);
    import mod_arith_pkg::*;

    logic    host_act;
    req_id_e winner;
    req_id_e last_q;

    assign host_act = host_we_i | host_re_i;

    // ==================================================================
    // Priority selection, host first then round-robin
    // ==================================================================

    always_comb begin
        winner = REQ_HOST;
        if (!host_act) begin
            if (lane0_req_i && lane1_req_i) begin
                // Last winner loses the tie
                winner = (last_q == REQ_LANE0) ? REQ_LANE1 : REQ_LANE0;
            end else if (lane0_req_i) begin
                winner = REQ_LANE0;
            end else if (lane1_req_i) begin
                winner = REQ_LANE1;
            end
        end
    end

    assign lane0_gnt_o = lane0_req_i && (winner == REQ_LANE0);
    assign lane1_gnt_o = lane1_req_i && (winner == REQ_LANE1);

    // Pointer moves only on lane grants
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            last_q <= REQ_LANE1;
        end else if (lane0_gnt_o) begin
            last_q <= REQ_LANE0;
        end else if (lane1_gnt_o) begin
            last_q <= REQ_LANE1;
        end
    end

    // ==================================================================
    // Port mux
    // ==================================================================

    assign ram_en_o = host_act | lane0_gnt_o | lane1_gnt_o;

    always_comb begin
        case (winner)
            REQ_LANE0: begin
                ram_we_o    = lane0_gnt_o & lane0_we_i;
                ram_addr_o  = lane0_addr_i;
                ram_wdata_o = lane0_wdata_i;
            end
            REQ_LANE1: begin
                ram_we_o    = lane1_gnt_o & lane1_we_i;
                ram_addr_o  = lane1_addr_i;
                ram_wdata_o = lane1_wdata_i;
            end
            default: begin
                ram_we_o    = host_we_i;
                ram_addr_o  = host_addr_i;
                ram_wdata_o = host_wdata_i;
            end
        endcase
    end

    // Read data goes to everyone, each requester knows its own slot
    assign rdata_o = ram_rdata_i;

endmodule

//--- hw/mod_lane.sv
`timescale 1ns/1ps

module mod_lane (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  mod_arith_pkg::word_t    prime_i,
    // Command port
    input  logic                    cmd_en_i,
    input  mod_arith_pkg::lane_op_e cmd_op_i,
    input  mod_arith_pkg::addr_t    cmd_addr_a_i,
    input  mod_arith_pkg::addr_t    cmd_addr_b_i,
    input  mod_arith_pkg::addr_t    cmd_addr_r_i,
    output logic                    busy_o,
    output logic                    done_o,
    // Memory request port
    input  logic                    mem_gnt_i,
    input  mod_arith_pkg::word_t    mem_rdata_i,
    output logic                    mem_req_o,
    output logic                    mem_we_o,
    output mod_arith_pkg::addr_t    mem_addr_o,
    output mod_arith_pkg::word_t    mem_wdata_o
);
    import mod_arith_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_A,
        S_RD_B,
        S_ADD,
        S_WAIT,
        S_WR
    } state_e;

    state_e   state_q;

    // Latched command
    lane_op_e op_q;
    addr_t    addr_a_q;
    addr_t    addr_b_q;
    addr_t    addr_r_q;

    // Operand A arrives the cycle after its grant
    logic     cap_a_q;
    word_t    opa_q;

    // Arithmetic unit
    logic     add_en;
    logic     ready;
    word_t    res;
    word_t    res_q;

    // ==================================================================
    // Sequencer
    // ==================================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= S_IDLE;
            done_o  <= 1'b0;
            cap_a_q <= 1'b0;
        end else if (zeroize_i) begin
            // Abort silently
            state_q <= S_IDLE;
            done_o  <= 1'b0;
            cap_a_q <= 1'b0;
        end else begin
            done_o  <= 1'b0;
            cap_a_q <= (state_q == S_RD_A) && mem_gnt_i;
            case (state_q)
                S_IDLE: if (cmd_en_i) state_q <= S_RD_A;
                S_RD_A: if (mem_gnt_i) state_q <= S_RD_B;
                S_RD_B: if (mem_gnt_i) state_q <= S_ADD;
                // add_en fires here with B straight off the read bus
                S_ADD:  state_q <= S_WAIT;
                S_WAIT: if (ready) state_q <= S_WR;
                S_WR: begin
                    if (mem_gnt_i) begin
                        state_q <= S_IDLE;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Command and operand registers
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            op_q     <= OP_ADD;
            addr_a_q <= '0;
            addr_b_q <= '0;
            addr_r_q <= '0;
            opa_q    <= '0;
            res_q    <= '0;
        end else begin
            // Busy lanes ignore new strobes
            if (state_q == S_IDLE && cmd_en_i) begin
                op_q     <= cmd_op_i;
                addr_a_q <= cmd_addr_a_i;
                addr_b_q <= cmd_addr_b_i;
                addr_r_q <= cmd_addr_r_i;
            end
            if (cap_a_q) begin
                opa_q <= mem_rdata_i;
            end
            // Hold the result for the write, however long it waits
            if (ready) begin
                res_q <= res;
            end
        end
    end

    assign add_en = (state_q == S_ADD);

    add_sub_mod u_add_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (add_en),
        .sub_i     (op_q == OP_SUB),
        .opa_i     (opa_q),
        .opb_i     (mem_rdata_i),
        .prime_i   (prime_i),
        .res_o     (res),
        .ready_o   (ready)
    );

    // ==================================================================
    // Memory request outputs
    // ==================================================================

    assign mem_req_o   = (state_q == S_RD_A) || (state_q == S_RD_B) || (state_q == S_WR);
    assign mem_we_o    = (state_q == S_WR);
    assign mem_wdata_o = res_q;

    always_comb begin
        case (state_q)
            S_RD_A:  mem_addr_o = addr_a_q;
            S_RD_B:  mem_addr_o = addr_b_q;
            default: mem_addr_o = addr_r_q;
        endcase
    end

    assign busy_o = (state_q != S_IDLE);

endmodule

//--- hw/mod_arith_top.sv
`timescale 1ns/1ps

module mod_arith_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  mod_arith_pkg::word_t    prime_i,
    // Host port
    input  logic                    host_we_i,
    input  logic                    host_re_i,
    input  mod_arith_pkg::addr_t    host_addr_i,
    input  mod_arith_pkg::word_t    host_wdata_i,
    output mod_arith_pkg::word_t    host_rdata_o,
    // Lane 0 command port
    input  logic                    cmd_en0_i,
    input  mod_arith_pkg::lane_op_e cmd_op0_i,
    input  mod_arith_pkg::addr_t    cmd_addr_a0_i,
    input  mod_arith_pkg::addr_t    cmd_addr_b0_i,
    input  mod_arith_pkg::addr_t    cmd_addr_r0_i,
    output logic                    busy0_o,
    output logic                    done0_o,
    // Lane 1 command port
    input  logic                    cmd_en1_i,
    input  mod_arith_pkg::lane_op_e cmd_op1_i,
    input  mod_arith_pkg::addr_t    cmd_addr_a1_i,
    input  mod_arith_pkg::addr_t    cmd_addr_b1_i,
    input  mod_arith_pkg::addr_t    cmd_addr_r1_i,
    output logic                    busy1_o,
    output logic                    done1_o
);
    import mod_arith_pkg::*;

    // Lane to arbiter
    logic  l0_req;
    logic  l0_we;
    addr_t l0_addr;
    word_t l0_wdata;
    logic  l0_gnt;
    logic  l1_req;
    logic  l1_we;
    addr_t l1_addr;
    word_t l1_wdata;
    logic  l1_gnt;

    // Arbiter to memory
    logic  ram_en;
    logic  ram_we;
    addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;

    // Shared read bus, also the host read data
    word_t rd_bus;

    assign host_rdata_o = rd_bus;

    operand_ram u_ram (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (ram_en),
        .we_i      (ram_we),
        .addr_i    (ram_addr),
        .wdata_i   (ram_wdata),
        .rdata_o   (ram_rdata)
    );

    mem_arbiter u_arb (
        .clk           (clk),
        .reset_n       (reset_n),
        .host_we_i     (host_we_i),
        .host_re_i     (host_re_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .lane0_req_i   (l0_req),
        .lane0_we_i    (l0_we),
        .lane0_addr_i  (l0_addr),
        .lane0_wdata_i (l0_wdata),
        .lane0_gnt_o   (l0_gnt),
        .lane1_req_i   (l1_req),
        .lane1_we_i    (l1_we),
        .lane1_addr_i  (l1_addr),
        .lane1_wdata_i (l1_wdata),
        .lane1_gnt_o   (l1_gnt),
        .ram_rdata_i   (ram_rdata),
        .ram_en_o      (ram_en),
        .ram_we_o      (ram_we),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .rdata_o       (rd_bus)
    );

    // ==================================================================
    // Arithmetic lanes
    // ==================================================================

    mod_lane u_lane0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .prime_i      (prime_i),
        .cmd_en_i     (cmd_en0_i),
        .cmd_op_i     (cmd_op0_i),
        .cmd_addr_a_i (cmd_addr_a0_i),
        .cmd_addr_b_i (cmd_addr_b0_i),
        .cmd_addr_r_i (cmd_addr_r0_i),
        .busy_o       (busy0_o),
        .done_o       (done0_o),
        .mem_gnt_i    (l0_gnt),
        .mem_rdata_i  (rd_bus),
        .mem_req_o    (l0_req),
        .mem_we_o     (l0_we),
        .mem_addr_o   (l0_addr),
        .mem_wdata_o  (l0_wdata)
    );

    mod_lane u_lane1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .prime_i      (prime_i),
        .cmd_en_i     (cmd_en1_i),
        .cmd_op_i     (cmd_op1_i),
        .cmd_addr_a_i (cmd_addr_a1_i),
        .cmd_addr_b_i (cmd_addr_b1_i),
        .cmd_addr_r_i (cmd_addr_r1_i),
        .busy_o       (busy1_o),
        .done_o       (done1_o),
        .mem_gnt_i    (l1_gnt),
        .mem_rdata_i  (rd_bus),
        .mem_req_o    (l1_req),
        .mem_we_o     (l1_we),
        .mem_addr_o   (l1_addr),
        .mem_wdata_o  (l1_wdata)
    );

endmodule

//--- verif/mod_arith_tb.sv
`timescale 1ns/1ps
`include "mod_arith_defines.svh"

module mod_arith_tb;
    import mod_arith_pkg::*;

    // Largest prime below 2^64
    localparam word_t       P              = 64'hFFFF_FFFF_FFFF_FFC5;
    localparam int unsigned SEED           = 32'hb1e56d43;
    // Upper bound on lane commands in the sequence below
    localparam int          NUM_CMDS       = 26;
    localparam int          TIMEOUT_CYCLES = NUM_CMDS * 40 + 200;

    logic     clk;
    logic     reset_n;
    logic     zeroize;
    logic     host_we;
    logic     host_re;
    addr_t    host_addr;
    word_t    host_wdata;
    word_t    host_rdata;
    logic     cmd_en0;
    lane_op_e cmd_op0;
    addr_t    cmd_a0;
    addr_t    cmd_b0;
    addr_t    cmd_r0;
    logic     busy0;
    logic     done0;
    logic     cmd_en1;
    lane_op_e cmd_op1;
    addr_t    cmd_a1;
    addr_t    cmd_b1;
    addr_t    cmd_r1;
    logic     busy1;
    logic     done1;

    // Mirror of the operand memory
    word_t    shadow [`MEM_DEPTH];
    word_t    rd_expect;
    word_t    rd_expect_q;
    logic     first_cmd;
    int       errors = 0;
    int       done_cnt0 = 0;
    int       done_cnt1 = 0;
    int       exp_done0;
    int       exp_done1;

    mod_arith_top DUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize),
        .prime_i       (P),
        .host_we_i     (host_we),
        .host_re_i     (host_re),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .host_rdata_o  (host_rdata),
        .cmd_en0_i     (cmd_en0),
        .cmd_op0_i     (cmd_op0),
        .cmd_addr_a0_i (cmd_a0),
        .cmd_addr_b0_i (cmd_b0),
        .cmd_addr_r0_i (cmd_r0),
        .busy0_o       (busy0),
        .done0_o       (done0),
        .cmd_en1_i     (cmd_en1),
        .cmd_op1_i     (cmd_op1),
        .cmd_addr_a1_i (cmd_a1),
        .cmd_addr_b1_i (cmd_b1),
        .cmd_addr_r1_i (cmd_r1),
        .busy1_o       (busy1),
        .done1_o       (done1)
    );

    always #10 clk = ~clk;

    // Expectation of a host read held for the cycle its data returns
    always @(posedge clk) begin
        rd_expect_q <= rd_expect;
    end

    // Done pulses seen per lane
    always @(posedge clk) begin
        if (reset_n && done0) done_cnt0++;
        if (reset_n && done1) done_cnt1++;
    end

    // ======================================================================
    // Checkers
    // ======================================================================

    // Both lanes quiet from reset up to the first command
    a_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        !first_cmd |-> (!busy0 && !done0 && !busy1 && !done1))
    else begin
        errors++;
        $display("error %0t: lane busy or done before the first command", $time);
    end

    // Host read data one cycle after the read
    a_host_read: assert property (@(posedge clk) disable iff (!reset_n)
        host_re |=> (host_rdata == rd_expect_q))
    else begin
        errors++;
        $display("error %0t: host read got %h, expected %h", $time, host_rdata, rd_expect_q);
    end

    // Done is a single-cycle pulse with the lane back in idle
    a_done0: assert property (@(posedge clk) disable iff (!reset_n)
        done0 |-> !busy0 ##1 !done0)
    else begin
        errors++;
        $display("error %0t: lane 0 done not a clean one-cycle pulse", $time);
    end

    a_done1: assert property (@(posedge clk) disable iff (!reset_n)
        done1 |-> !busy1 ##1 !done1)
    else begin
        errors++;
        $display("error %0t: lane 1 done not a clean one-cycle pulse", $time);
    end

    // Zeroize aborts both lanes silently
    a_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize |=> (!busy0 && !busy1 && !done0 && !done1))
    else begin
        errors++;
        $display("error %0t: lane still busy or done after zeroize", $time);
    end

    // ======================================================================
    // Reference model and stimulus helpers
    // ======================================================================

    function automatic word_t mod_add(input word_t a, input word_t b);
        logic [`REG_SIZE:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, P}) begin
            s = s - {1'b0, P};
        end
        return s[`REG_SIZE-1:0];
    endfunction

    function automatic word_t mod_sub(input word_t a, input word_t b);
        if (a >= b) begin
            return a - b;
        end
        // Borrow wraps back into 0..p-1
        return a + (P - b);
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = {$urandom, $urandom};
        return w % P;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input addr_t a, input word_t v);
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = v;
        shadow[a]  = v;
        step();
        host_we    = 1'b0;
    endtask

    task automatic read_check(input addr_t a);
        host_re   = 1'b1;
        host_addr = a;
        rd_expect = shadow[a];
        step();
        host_re   = 1'b0;
        step();
    endtask

    // Drives one lane strobe and updates the mirror for tracked commands
    task automatic set_cmd(input int lane, input lane_op_e op, input addr_t a,
                           input addr_t b, input addr_t r, input bit track);
        word_t res;
        res = (op == OP_SUB) ? mod_sub(shadow[a], shadow[b]) : mod_add(shadow[a], shadow[b]);
        first_cmd = 1'b1;
        if (lane == 0) begin
            cmd_en0 = 1'b1;
            cmd_op0 = op;
            cmd_a0  = a;
            cmd_b0  = b;
            cmd_r0  = r;
        end else begin
            cmd_en1 = 1'b1;
            cmd_op1 = op;
            cmd_a1  = a;
            cmd_b1  = b;
            cmd_r1  = r;
        end
        if (track) begin
            shadow[r] = res;
            if (lane == 0) exp_done0++;
            else exp_done1++;
        end
    endtask

    task automatic clear_cmd();
        cmd_en0 = 1'b0;
        cmd_en1 = 1'b0;
    endtask

    // Waits until every tracked command has pulsed done
    task automatic wait_done();
        while (done_cnt0 < exp_done0 || done_cnt1 < exp_done1) begin
            step();
        end
    endtask

    task automatic run_single(input int lane, input lane_op_e op, input addr_t a,
                              input addr_t b, input addr_t r);
        set_cmd(lane, op, a, b, r, 1'b1);
        step();
        clear_cmd();
        wait_done();
        read_check(r);
    endtask

    task automatic check_done_counts();
        assert (done_cnt0 == exp_done0 && done_cnt1 == exp_done1) else begin
            errors++;
            $display("error %0t: done pulses %0d/%0d, expected %0d/%0d", $time,
                     done_cnt0, done_cnt1, exp_done0, exp_done1);
        end
    endtask

    // ======================================================================
    // Watchdog
    // ======================================================================

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles, a lane never finished", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        host_we    = 1'b0;
        host_re    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        cmd_en0    = 1'b0;
        cmd_op0    = OP_ADD;
        cmd_a0     = '0;
        cmd_b0     = '0;
        cmd_r0     = '0;
        cmd_en1    = 1'b0;
        cmd_op1    = OP_ADD;
        cmd_a1     = '0;
        cmd_b1     = '0;
        cmd_r1     = '0;
        first_cmd  = 1'b0;
        rd_expect  = '0;
        exp_done0  = 0;
        exp_done1  = 0;
        for (int i = 0; i < `MEM_DEPTH; i++) shadow[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        step();
        step();

        // Edge values in the low words and random words elsewhere
        write_word(0, '0);
        write_word(1, P - 1);
        write_word(2, 64'd1);
        for (int i = 3; i < `MEM_DEPTH; i++) write_word(addr_t'(i), rand_word());
        for (int i = 0; i < `MEM_DEPTH; i++) read_check(addr_t'(i));

        // Lane 0 adds that wrap past 2^64, hit p exactly or give zero
        run_single(0, OP_ADD, 1, 1, 10);
        run_single(0, OP_ADD, 1, 2, 10);
        run_single(0, OP_ADD, 0, 1, 10);
        run_single(0, OP_ADD, 0, 0, 10);
        run_single(0, OP_ADD, 3, 4, 10);
        // Lane 1 subtracts with borrows and edge values
        run_single(1, OP_SUB, 0, 1, 11);
        run_single(1, OP_SUB, 1, 0, 11);
        run_single(1, OP_SUB, 2, 1, 11);
        run_single(1, OP_SUB, 1, 1, 11);
        run_single(1, OP_SUB, 3, 4, 11);
        for (int i = 0; i < 6; i++) begin
            run_single(i % 2, lane_op_e'($urandom_range(0, 1)),
                       addr_t'($urandom_range(0, 9)), addr_t'($urandom_range(0, 9)),
                       addr_t'(10 + (i % 2)));
        end

        // Both lanes at once while the host writes elsewhere
        for (int round = 0; round < 2; round++) begin
            for (int i = 3; i < 7; i++) write_word(addr_t'(i), rand_word());
            set_cmd(0, OP_ADD, 3, 4, 12, 1'b1);
            set_cmd(1, OP_SUB, 5, 6, 13, 1'b1);
            step();
            clear_cmd();
            // Lane 0 is still busy so this strobe must vanish
            set_cmd(0, OP_SUB, 7, 8, 11, 1'b0);
            step();
            clear_cmd();
            for (int k = 0; k < 4; k++) begin
                write_word(addr_t'(14 + (k % 2)), rand_word());
                step();
            end
            wait_done();
            repeat (10) step();
            check_done_counts();
            for (int i = 11; i < 16; i++) read_check(addr_t'(i));
        end

        // Zeroize with both lanes in flight
        set_cmd(0, OP_ADD, 3, 4, 10, 1'b0);
        set_cmd(1, OP_SUB, 5, 6, 11, 1'b0);
        step();
        clear_cmd();
        step();
        step();
        zeroize = 1'b1;
        step();
        zeroize = 1'b0;
        for (int i = 0; i < `MEM_DEPTH; i++) shadow[i] = '0;
        repeat (12) step();
        check_done_counts();
        for (int i = 0; i < `MEM_DEPTH; i++) read_check(addr_t'(i));

        // Fresh commands after the wipe
        write_word(3, rand_word());
        write_word(4, rand_word());
        run_single(0, OP_ADD, 3, 4, 10);
        run_single(1, OP_SUB, 3, 4, 11);
        repeat (4) step();
        check_done_counts();

        $display("Checks complete, %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- mod_arith_top.f
+incdir+hw
hw/mod_arith_pkg.sv
hw/add_sub_mod.sv
hw/operand_ram.sv
hw/mem_arbiter.sv
hw/mod_lane.sv
hw/mod_arith_top.sv
verif/mod_arith_tb.sv

//--- Makefile
# Verilator build and run for the modular arithmetic engine

VERILATOR ?= verilator
TOP       ?= mod_arith_tb
FLIST     ?= mod_arith_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
